/* Makefile */
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= fetch_frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(VERILATOR), run $(TOP), search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "no result found in $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* fetch_frontend.f */
hw/rv32i_fetch_pkg.sv
hw/burst_deserializer.sv
hw/icache.sv
hw/instr_queue.sv
hw/fetch_ctrl.sv
hw/decode_classify.sv
hw/fetch_frontend.sv
test/tb_bmem_model.sv
test/tb_fetch_frontend.sv

/* hw/burst_deserializer.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_deserializer (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     refill_req_i,
    input  logic [31:0]                              refill_addr_i,
    output logic [rv32i_fetch_pkg::line_width_c-1:0] refill_line_o,
    output logic                                     refill_done_o,
    output logic [31:0]                              bmem_addr_o,
    output logic                                     bmem_read_o,
    input  logic                                     bmem_ready_i,
    input  logic [rv32i_fetch_pkg::beat_width_c-1:0] bmem_rdata_i,
    input  logic                                     bmem_rvalid_i
);
    import rv32i_fetch_pkg::*;

    localparam int cnt_w = $clog2(beats_per_line_c);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_collect
    } state_e;

    state_e                  state_q;
    logic [cnt_w-1:0]        beat_cnt_q;
    logic [line_width_c-1:0] line_q;

    // single-cycle read strobe, only while memory is ready
    assign bmem_read_o   = (state_q == st_request) && bmem_ready_i;
    assign refill_line_o = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= st_idle;
            beat_cnt_q    <= '0;
            refill_done_o <= 1'b0;
        end else begin
            refill_done_o <= 1'b0;
            case (state_q)
                st_idle: begin
                    // done still visible means the old request is being retired
                    if (refill_req_i && !refill_done_o) begin
                        state_q <= st_request;
                    end
                end
                st_request: begin
                    if (bmem_ready_i) begin
                        state_q    <= st_collect;
                        beat_cnt_q <= '0;
                    end
                end
                st_collect: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (beat_cnt_q == cnt_w'(beats_per_line_c - 1)) begin
                            state_q       <= st_idle;
                            refill_done_o <= 1'b1;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (state_q == st_idle && refill_req_i) begin
            bmem_addr_o <= {refill_addr_i[31:5], 5'b0};
        end
        if (state_q == st_collect && bmem_rvalid_i) begin
            line_q[beat_cnt_q*beat_width_c +: beat_width_c] <= bmem_rdata_i;
        end
    end

    // beats only come back for a read that was issued
    assert property (@(posedge clk) disable iff (rst)
        !(state_q == st_idle && bmem_rvalid_i))
        else $error("burst beat while deserializer idle");

endmodule

`default_nettype wire

/* hw/decode_classify.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_classify (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_i,
    input  logic                       empty_i,
    output logic                       deq_o,
    input  logic [31:0]                pc_i,
    input  logic [31:0]                inst_i,
    output logic                       dec_valid_o,
    input  logic                       dec_ready_i,
    output logic [31:0]                dec_pc_o,
    output logic [31:0]                dec_inst_o,
    output rv32i_fetch_pkg::op_type_e  dec_op_type_o,
    output logic [4:0]                 dec_rd_o,
    output logic [4:0]                 dec_rs1_o,
    output logic [4:0]                 dec_rs2_o
);
    import rv32i_fetch_pkg::*;

    // take a word when the output register is free or being taken
    assign deq_o = !empty_i && (!dec_valid_o || dec_ready_i);

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            dec_valid_o <= 1'b0;
        end else if (deq_o) begin
            dec_valid_o <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (deq_o) begin
            dec_pc_o      <= pc_i;
            dec_inst_o    <= inst_i;
            dec_op_type_o <= classify_opcode(inst_i[6:0]);
            dec_rd_o      <= inst_i[11:7];
            dec_rs1_o     <= inst_i[19:15];
            dec_rs2_o     <= inst_i[24:20];
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl #(
    parameter logic [31:0] RESET_PC = 32'haaaaa000
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     redirect_valid_i,
    input  logic [31:0]                              redirect_pc_i,
    output logic                                     cache_req_o,
    output logic [31:0]                              cache_addr_o,
    input  logic [rv32i_fetch_pkg::line_width_c-1:0] cache_line_i,
    input  logic                                     cache_resp_i,
    input  logic                                     full_i,
    output logic                                     enq_o,
    output logic [31:0]                              enq_pc_o,
    output logic [31:0]                              enq_inst_o
);
    import rv32i_fetch_pkg::*;

    logic [31:0] pc_q;

    // one-line buffer
    logic                    lb_valid_q;
    logic [31:5]             lb_tag_q;
    logic [line_width_c-1:0] lb_line_q;
    logic                    lb_hit;

    logic        req_q;
    logic [31:0] req_addr_q;
    // response of a request issued before a redirect
    logic        drop_q;

    assign lb_hit = lb_valid_q && (lb_tag_q == pc_q[31:5]);

    // words leave only from the line buffer, one per cycle
    assign enq_o      = lb_hit && !full_i;
    assign enq_pc_o   = pc_q;
    assign enq_inst_o = lb_line_q[{pc_q[4:2], 5'b0} +: 32];

    assign cache_req_o  = req_q;
    assign cache_addr_o = req_addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q       <= RESET_PC;
            lb_valid_q <= 1'b0;
            req_q      <= 1'b0;
            drop_q     <= 1'b0;
        end else begin
            if (req_q && cache_resp_i) begin
                req_q  <= 1'b0;
                drop_q <= 1'b0;
                if (!drop_q && !redirect_valid_i) begin
                    lb_valid_q <= 1'b1;
                end
            end else if (!req_q && !lb_hit && !redirect_valid_i) begin
                req_q <= 1'b1;
            end

            if (redirect_valid_i) begin
                pc_q <= redirect_pc_i;
                if (req_q && !cache_resp_i) begin
                    drop_q <= 1'b1;
                end
            end else if (enq_o) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // line and address payload
    always_ff @(posedge clk) begin
        if (req_q && cache_resp_i && !drop_q && !redirect_valid_i) begin
            lb_line_q <= cache_line_i;
            lb_tag_q  <= req_addr_q[31:5];
        end
        if (!req_q && !lb_hit) begin
            req_addr_q <= {pc_q[31:5], 5'b0};
        end
    end

    // the cache only answers a request that is outstanding
    assert property (@(posedge clk) disable iff (rst)
        cache_resp_i |-> cache_req_o)
        else $error("cache response without an outstanding request");

endmodule

`default_nettype wire

/* hw/fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
    parameter logic [31:0] RESET_PC    = 32'haaaaa000,
    parameter int          NUM_SETS    = 8,
    parameter int          QUEUE_DEPTH = 8
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     redirect_valid_i,
    input  logic [31:0]                              redirect_pc_i,
    output logic [31:0]                              bmem_addr_o,
    output logic                                     bmem_read_o,
    input  logic                                     bmem_ready_i,
    input  logic [rv32i_fetch_pkg::beat_width_c-1:0] bmem_rdata_i,
    input  logic                                     bmem_rvalid_i,
    output logic                                     dec_valid_o,
    input  logic                                     dec_ready_i,
    output logic [31:0]                              dec_pc_o,
    output logic [31:0]                              dec_inst_o,
    output rv32i_fetch_pkg::op_type_e                dec_op_type_o,
    output logic [4:0]                               dec_rd_o,
    output logic [4:0]                               dec_rs1_o,
    output logic [4:0]                               dec_rs2_o
);
    import rv32i_fetch_pkg::*;

    // fetch_ctrl to icache
    logic                    cache_req;
    logic [31:0]             cache_addr;
    logic [line_width_c-1:0] cache_line;
    logic                    cache_resp;

    // icache to deserializer
    logic                    refill_req;
    logic [31:0]             refill_addr;
    logic [line_width_c-1:0] refill_line;
    logic                    refill_done;

    // queue links
    logic        enq;
    logic [31:0] enq_pc;
    logic [31:0] enq_inst;
    logic        full;
    logic        deq;
    logic [31:0] deq_pc;
    logic [31:0] deq_inst;
    logic        empty;

    fetch_ctrl #(
        .RESET_PC (RESET_PC)
    ) fetch_ctrl_inst (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .cache_req_o      (cache_req),
        .cache_addr_o     (cache_addr),
        .cache_line_i     (cache_line),
        .cache_resp_i     (cache_resp),
        .full_i           (full),
        .enq_o            (enq),
        .enq_pc_o         (enq_pc),
        .enq_inst_o       (enq_inst)
    );

    icache #(
        .NUM_SETS (NUM_SETS)
    ) icache_inst (
        .clk           (clk),
        .rst           (rst),
        .cache_req_i   (cache_req),
        .cache_addr_i  (cache_addr),
        .cache_line_o  (cache_line),
        .cache_resp_o  (cache_resp),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .refill_line_i (refill_line),
        .refill_done_i (refill_done)
    );

    burst_deserializer burst_deserializer_inst (
        .clk           (clk),
        .rst           (rst),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .refill_line_o (refill_line),
        .refill_done_o (refill_done),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    // redirect flushes both queue and decode
    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) instr_queue_inst (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (redirect_valid_i),
        .enq_i      (enq),
        .enq_pc_i   (enq_pc),
        .enq_inst_i (enq_inst),
        .full_o     (full),
        .deq_i      (deq),
        .deq_pc_o   (deq_pc),
        .deq_inst_o (deq_inst),
        .empty_o    (empty)
    );

    decode_classify decode_classify_inst (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (redirect_valid_i),
        .empty_i       (empty),
        .deq_o         (deq),
        .pc_i          (deq_pc),
        .inst_i        (deq_inst),
        .dec_valid_o   (dec_valid_o),
        .dec_ready_i   (dec_ready_i),
        .dec_pc_o      (dec_pc_o),
        .dec_inst_o    (dec_inst_o),
        .dec_op_type_o (dec_op_type_o),
        .dec_rd_o      (dec_rd_o),
        .dec_rs1_o     (dec_rs1_o),
        .dec_rs2_o     (dec_rs2_o)
    );

endmodule

`default_nettype wire

/* hw/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int NUM_SETS = 8
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     cache_req_i,
    input  logic [31:0]                              cache_addr_i,
    output logic [rv32i_fetch_pkg::line_width_c-1:0] cache_line_o,
    output logic                                     cache_resp_o,
    output logic                                     refill_req_o,
    output logic [31:0]                              refill_addr_o,
    input  logic [rv32i_fetch_pkg::line_width_c-1:0] refill_line_i,
    input  logic                                     refill_done_i
);
    import rv32i_fetch_pkg::*;

    localparam int offset_w = $clog2(line_width_c / 8);
    localparam int idx_w    = $clog2(NUM_SETS);
    localparam int tag_w    = 32 - offset_w - idx_w;

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_refill
    } state_e;

    state_e state_q;
    logic [31:0] addr_q;

    logic [line_width_c-1:0] data_arr [NUM_SETS];
    logic [tag_w-1:0]        tag_arr  [NUM_SETS];
    logic [NUM_SETS-1:0]     valid_q;

    logic [idx_w-1:0] idx;
    logic [tag_w-1:0] tag;
    logic             hit;

    assign idx = addr_q[offset_w +: idx_w];
    assign tag = addr_q[31 -: tag_w];
    assign hit = valid_q[idx] && (tag_arr[idx] == tag);

    // response comes straight out of the compare cycle
    assign cache_resp_o  = (state_q == st_compare) && hit;
    assign cache_line_o  = data_arr[idx];
    assign refill_req_o  = (state_q == st_refill);
    assign refill_addr_o = {addr_q[31:offset_w], {offset_w{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            valid_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (cache_req_i) begin
                        state_q <= st_compare;
                    end
                end
                st_compare: begin
                    state_q <= hit ? st_idle : st_refill;
                end
                st_refill: begin
                    if (refill_done_i) begin
                        // line installed, compare again to answer
                        valid_q[idx] <= 1'b1;
                        state_q      <= st_compare;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && cache_req_i) begin
            addr_q <= cache_addr_i;
        end
        if (state_q == st_refill && refill_done_i) begin
            data_arr[idx] <= refill_line_i;
            tag_arr[idx]  <= tag;
        end
    end

    // the deserializer only finishes a refill that was asked for
    assert property (@(posedge clk) disable iff (rst)
        refill_done_i |-> refill_req_o)
        else $error("refill done without a refill request");

endmodule

`default_nettype wire

/* hw/instr_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush_i,
    input  logic        enq_i,
    input  logic [31:0] enq_pc_i,
    input  logic [31:0] enq_inst_i,
    output logic        full_o,
    input  logic        deq_i,
    output logic [31:0] deq_pc_o,
    output logic [31:0] deq_inst_o,
    output logic        empty_o
);
    localparam int ptr_w = $clog2(QUEUE_DEPTH);

    // extra msb tells full from empty
    logic [ptr_w:0] head_q;
    logic [ptr_w:0] tail_q;

    logic [31:0] pc_mem   [QUEUE_DEPTH];
    logic [31:0] inst_mem [QUEUE_DEPTH];

    assign empty_o = (head_q == tail_q);
    assign full_o  = (head_q[ptr_w] != tail_q[ptr_w]) &&
                     (head_q[ptr_w-1:0] == tail_q[ptr_w-1:0]);

    // head entry shows without a read cycle
    assign deq_pc_o   = pc_mem[head_q[ptr_w-1:0]];
    assign deq_inst_o = inst_mem[head_q[ptr_w-1:0]];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (enq_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (deq_i) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq_i) begin
            pc_mem[tail_q[ptr_w-1:0]]   <= enq_pc_i;
            inst_mem[tail_q[ptr_w-1:0]] <= enq_inst_i;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        enq_i |-> !full_o)
        else $error("enqueue into full instruction queue");

    assert property (@(posedge clk) disable iff (rst)
        deq_i |-> !empty_o)
        else $error("dequeue from empty instruction queue");

endmodule

`default_nettype wire

/* hw/rv32i_fetch_pkg.sv */
`default_nettype none

package rv32i_fetch_pkg;

    localparam int line_width_c     = 256;
    localparam int beat_width_c     = 64;
    localparam int beats_per_line_c = line_width_c / beat_width_c;

    // base opcodes of rv32i
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011,
        op_b_br    = 7'b1100011,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011
    } rv32i_opcode_e;

    // operation type as seen by the reorder buffer
    typedef enum logic [1:0] {
        op_int     = 2'd0,
        op_br      = 2'd1,
        op_mem     = 2'd2,
        op_illegal = 2'd3
    } op_type_e;

    function automatic op_type_e classify_opcode(input logic [6:0] opcode);
        case (opcode)
            op_b_lui, op_b_auipc, op_b_imm, op_b_reg: return op_int;
            op_b_br, op_b_jal, op_b_jalr:            return op_br;
            op_b_load, op_b_store:                   return op_mem;
            default:                                 return op_illegal;
        endcase
    endfunction

endpackage

`default_nettype wire

/* test/tb_bmem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bmem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] bmem_addr_i,
    input  logic        bmem_read_i,
    output logic        bmem_ready_o,
    output logic [63:0] bmem_rdata_o,
    output logic        bmem_rvalid_o,
    output logic [31:0] read_count_o
);
    logic [31:0] rand_state;
    logic [31:0] beat_addr;
    int          beats_left;
    logic        rst_seen;
    logic        read_seen;
    logic [31:0] addr_seen;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // opcode column of the program image, by word index inside 64 bytes
    function automatic logic [6:0] opcode_at(input logic [3:0] idx);
        case (idx)
            4'd0:    return 7'b0110111;
            4'd1:    return 7'b0010111;
            4'd2:    return 7'b0010011;
            4'd3:    return 7'b0110011;
            4'd4:    return 7'b1100011;
            4'd5:    return 7'b1101111;
            4'd6:    return 7'b1100111;
            4'd7:    return 7'b0000011;
            4'd8:    return 7'b0100011;
            4'd9:    return 7'b1110011;
            4'd10:   return 7'b0001111;
            4'd11:   return 7'b0010011;
            4'd12:   return 7'b0000000;
            4'd13:   return 7'b0000011;
            4'd14:   return 7'b1111111;
            default: return 7'b0110011;
        endcase
    endfunction

    // upper address bits folded into the top of the word
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[26:2] ^ {addr[31:27], 20'h0}, opcode_at(addr[5:2])};
    endfunction

    initial begin
        bmem_ready_o  = 1'b0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
        read_count_o  = '0;
        rand_state    = 32'h7711;
        beat_addr     = '0;
        beats_left    = 0;
        forever begin
            @(posedge clk);
            rst_seen  = rst;
            read_seen = bmem_read_i && bmem_ready_o;
            addr_seen = bmem_addr_i;
            #1;
            rand_state    = lcg_next(rand_state);
            bmem_rvalid_o = 1'b0;
            if (rst_seen) begin
                beats_left   = 0;
                bmem_ready_o = 1'b0;
            end else begin
                if (read_seen) begin
                    beat_addr    = {addr_seen[31:5], 5'b0};
                    beats_left   = 4;
                    read_count_o = read_count_o + 32'd1;
                end else if (beats_left != 0 && rand_state[31:30] != 2'b00) begin
                    // beats in address order, idle cycles between some of them
                    bmem_rvalid_o = 1'b1;
                    bmem_rdata_o  = {word_at(beat_addr + 32'd4), word_at(beat_addr)};
                    beat_addr     = beat_addr + 32'd8;
                    beats_left    = beats_left - 1;
                end
                bmem_ready_o = (beats_left == 0) && !read_seen && (rand_state[29:28] != 2'b00);
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;
    import rv32i_fetch_pkg::*;

    localparam logic [31:0] reset_pc_c    = 32'haaaaa000;
    localparam int          num_sets_c    = 8;
    localparam int          queue_depth_c = 8;
    localparam int          wait_limit_c  = 2000;

    logic        clk;
    logic        rst;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic [31:0] bmem_addr;
    logic        bmem_read;
    logic        bmem_ready;
    logic [63:0] bmem_rdata;
    logic        bmem_rvalid;
    logic        dec_valid;
    logic        dec_ready;
    logic [31:0] dec_pc;
    logic [31:0] dec_inst;
    op_type_e    dec_op_type;
    logic [4:0]  dec_rd;
    logic [4:0]  dec_rs1;
    logic [4:0]  dec_rs2;
    logic [31:0] read_count;

    logic [31:0] exp_pc;
    logic [31:0] rand_state;
    logic [31:0] reads_before;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          errors_before;
    logic        timed_out;

    fetch_frontend #(
        .RESET_PC    (reset_pc_c),
        .NUM_SETS    (num_sets_c),
        .QUEUE_DEPTH (queue_depth_c)
    ) fetch_frontend_inst (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .bmem_addr_o      (bmem_addr),
        .bmem_read_o      (bmem_read),
        .bmem_ready_i     (bmem_ready),
        .bmem_rdata_i     (bmem_rdata),
        .bmem_rvalid_i    (bmem_rvalid),
        .dec_valid_o      (dec_valid),
        .dec_ready_i      (dec_ready),
        .dec_pc_o         (dec_pc),
        .dec_inst_o       (dec_inst),
        .dec_op_type_o    (dec_op_type),
        .dec_rd_o         (dec_rd),
        .dec_rs1_o        (dec_rs1),
        .dec_rs2_o        (dec_rs2)
    );

    tb_bmem_model bmem_model_inst (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid),
        .read_count_o  (read_count)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected op type and opcode per word index, illegal ones included
    function automatic logic [8:0] table_entry(input logic [3:0] idx);
        case (idx)
            4'd0:    return {op_int, 7'b0110111};
            4'd1:    return {op_int, 7'b0010111};
            4'd2:    return {op_int, 7'b0010011};
            4'd3:    return {op_int, 7'b0110011};
            4'd4:    return {op_br, 7'b1100011};
            4'd5:    return {op_br, 7'b1101111};
            4'd6:    return {op_br, 7'b1100111};
            4'd7:    return {op_mem, 7'b0000011};
            4'd8:    return {op_mem, 7'b0100011};
            4'd9:    return {op_illegal, 7'b1110011};
            4'd10:   return {op_illegal, 7'b0001111};
            4'd11:   return {op_int, 7'b0010011};
            4'd12:   return {op_illegal, 7'b0000000};
            4'd13:   return {op_mem, 7'b0000011};
            4'd14:   return {op_illegal, 7'b1111111};
            default: return {op_int, 7'b0110011};
        endcase
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [8:0] entry;
        entry = table_entry(addr[5:2]);
        return {addr[26:2] ^ {addr[31:27], 20'h0}, entry[6:0]};
    endfunction

    function automatic op_type_e table_type(input logic [31:0] addr);
        logic [8:0] entry;
        entry = table_entry(addr[5:2]);
        return op_type_e'(entry[8:7]);
    endfunction

    // rd, rs1, rs2 packed in that order
    function automatic logic [14:0] reg_fields(input logic [31:0] word);
        return {word[11:7], word[19:15], word[24:20]};
    endfunction

    task automatic note_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, want);
        error_count = error_count + 1;
    endtask

    task automatic note_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        error_count = error_count + 1;
    endtask

    // expected pc follows reset, redirects and accepted words
    always @(posedge clk) begin
        if (rst) begin
            exp_pc <= reset_pc_c;
        end else if (redirect_valid) begin
            exp_pc <= redirect_pc;
        end else if (dec_valid && dec_ready) begin
            exp_pc <= exp_pc + 32'd4;
        end
    end

    assert property (@(posedge clk) rst |=> !bmem_read && !dec_valid)
        else note_failure("burst read or decode valid active right after reset");

    assert property (@(posedge clk) disable iff (rst)
        dec_valid && dec_ready |-> dec_pc == exp_pc)
        else note_mismatch("decoded pc", $sampled(dec_pc), $sampled(exp_pc));

    assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> dec_inst == model_word(dec_pc))
        else note_mismatch("instruction word", $sampled(dec_inst),
                           model_word($sampled(dec_pc)));

    assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> {dec_rd, dec_rs1, dec_rs2} == reg_fields(model_word(dec_pc)))
        else note_mismatch("register fields", {17'b0, $sampled({dec_rd, dec_rs1, dec_rs2})},
                           {17'b0, reg_fields(model_word($sampled(dec_pc)))});

    assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> dec_op_type == table_type(dec_pc))
        else note_mismatch("op type", {30'b0, $sampled(dec_op_type)},
                           {30'b0, table_type($sampled(dec_pc))});

    assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready && !redirect_valid |=>
        dec_valid && $stable(dec_pc) && $stable(dec_inst) && $stable(dec_op_type) &&
        $stable({dec_rd, dec_rs1, dec_rs2}))
        else note_failure("decode output changed while stalled");

    // caller sits 1 ns after a rising edge
    task automatic accept_words(input int count, input logic random_ready);
        int taken;
        int idle;
        taken = 0;
        idle  = 0;
        while (taken < count && !timed_out) begin
            @(posedge clk);
            if (dec_valid && dec_ready) begin
                taken = taken + 1;
                idle  = 0;
            end else begin
                idle = idle + 1;
            end
            #1;
            if (idle > wait_limit_c) begin
                $display("timeout: no decoded word accepted for %0d cycles", idle);
                timed_out = 1'b1;
            end else if (random_ready) begin
                rand_state = lcg_next(rand_state);
                dec_ready  = (rand_state[31:30] != 2'b00);
            end else begin
                dec_ready = 1'b1;
            end
        end
    endtask

    // stall decode until the memory bus stays idle
    task automatic wait_quiet();
        int quiet;
        int waited;
        quiet     = 0;
        waited    = 0;
        dec_ready = 1'b0;
        while (quiet < 16 && !timed_out) begin
            @(posedge clk);
            quiet  = (!bmem_read && !bmem_rvalid) ? quiet + 1 : 0;
            waited = waited + 1;
            #1;
            if (waited > wait_limit_c) begin
                $display("timeout: memory bus never went idle");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_read();
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && !timed_out) begin
            @(posedge clk);
            seen   = bmem_read;
            waited = waited + 1;
            #1;
            if (waited > wait_limit_c) begin
                $display("timeout: no burst read issued");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic redirect_to(input logic [31:0] addr);
        redirect_valid = 1'b1;
        redirect_pc    = addr;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        if (timed_out || error_count != errors_before) begin
            tests_failed = tests_failed + 1;
            $display("test %-22s failed, %0d mismatches", name, error_count - errors_before);
        end else begin
            $display("test %-22s ok", name);
        end
        errors_before = error_count;
    endtask

    initial begin
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        dec_ready      = 1'b0;
        rand_state     = 32'h7711;
        error_count    = 0;
        errors_before  = 0;
        tests_run      = 0;
        tests_failed   = 0;
        timed_out      = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        dec_ready = 1'b1;
        accept_words(1, 1'b0);
        finish_test("reset_first_word");

        accept_words(23, 1'b1);
        finish_test("stream_backpressure");

        // lines 0..4 of the reset region are resident, well within the sets
        wait_quiet();
        reads_before = read_count;
        redirect_to(reset_pc_c + 32'd4);
        accept_words(20, 1'b1);
        if (!timed_out) begin
            assert (read_count == reads_before)
                else note_mismatch("memory reads after resident redirect",
                                   read_count, reads_before);
        end
        finish_test("resident_redirect");

        redirect_to(32'h00001f00);
        accept_words(40, 1'b1);
        finish_test("far_redirect");

        // second redirect lands while a refill is in flight
        dec_ready = 1'b1;
        redirect_to(32'h12340010);
        wait_read();
        redirect_to(32'h00400008);
        accept_words(24, 1'b1);
        finish_test("redirect_during_miss");

        $display("tests run %0d, failed %0d, mismatches %0d%s", tests_run, tests_failed,
                 error_count, timed_out ? ", timed out" : "");
        if (error_count == 0 && tests_failed == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
